/* compile.f */
hw/usbDevicePkg.sv
hw/usbRom.sv
hw/ep0Ctrl.sv
hw/ep1Mouse.sv
hw/busArbiter.sv
hw/endpointRegs.sv
hw/usbDevice.sv
test/clkGen.sv
test/tbUsbDevice.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tbUsbDevice -f compile.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/tbUsbDevice.sv */
`timescale 1ns/1ps

module tbUsbDevice;

  localparam int NUM_TESTS = 7;
  localparam int SEED = 19829;

  // What the host expects back from EP0 for one setup packet
  typedef enum logic [1:0] {
    OUT_DATA,
    OUT_ZERO,
    OUT_STALL
  } outcome_t;

  // Setup byte 0 sits in the lowest eight bits
  typedef struct packed {
    logic [63:0]         setup;
    outcome_t            outcome;
    logic [5:0]          count;
    logic [5:0]          offset;
    logic [2:0]          reports;
    logic                busRst;
    usbDevicePkg::byte_t devAddr;
  } testEntry_t;

  logic                clk;
  logic                reset;
  logic                busReset;
  logic                setupWr;
  usbDevicePkg::byte_t setupByte;
  logic                ep0RdEn;
  logic                ep0Ack;
  logic                ep1RdEn;
  usbDevicePkg::byte_t ep0Data;
  logic                ep0Valid;
  logic                ep0TxReady;
  logic                ep0Stall;
  usbDevicePkg::byte_t ep1Data;
  logic                ep1Valid;
  usbDevicePkg::byte_t devAddr;

  testEntry_t          tbl [NUM_TESTS];
  string               testNames [NUM_TESTS];
  usbDevicePkg::byte_t descCopy [52];
  string               testName;
  logic                testOk;
  int                  passCount;
  int                  failCount;
  int                  errorCount;

  clkGen u_clkGen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  usbDevice dut_i (
    .clk_i        (clk),
    .reset_i      (reset),
    .busReset_i   (busReset),
    .setupWr_i    (setupWr),
    .setupByte_i  (setupByte),
    .ep0RdEn_i    (ep0RdEn),
    .ep0Ack_i     (ep0Ack),
    .ep1RdEn_i    (ep1RdEn),
    .ep0Data_o    (ep0Data),
    .ep0Valid_o   (ep0Valid),
    .ep0TxReady_o (ep0TxReady),
    .ep0Stall_o   (ep0Stall),
    .ep1Data_o    (ep1Data),
    .ep1Valid_o   (ep1Valid),
    .devAddr_o    (devAddr)
  );

  //////////////////////////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////////////////////////

  // A standard setup packet holds bmRequestType, bRequest, wValue, wIndex and wLength
  function automatic logic [63:0] mkSetup(usbDevicePkg::byte_t reqType,
                                          usbDevicePkg::byte_t request,
                                          logic [15:0] wValue,
                                          logic [15:0] wIndex,
                                          logic [15:0] wLength);
    return {wLength, wIndex, wValue, request, reqType};
  endfunction

  // A report carries buttons, dx and dy as the direction turns right, down, left, up
  function automatic usbDevicePkg::byte_t expectedReport(int report, int idx);
    int step;
    step = report % 4;
    if (idx == 1 && step == 0) return 8'h04;
    if (idx == 1 && step == 2) return 8'hFC;
    if (idx == 2 && step == 1) return 8'h04;
    if (idx == 2 && step == 3) return 8'hFC;
    return 8'h00;
  endfunction

  // Only the first mismatch of a test gets a line
  task automatic checkValue(input string what, input int expected, input int actual);
    if (expected != actual) begin
      errorCount++;
      if (testOk) begin
        $display("** Error %s %s: expected %0h, actual %0h", testName, what, expected, actual);
      end
      testOk = 1'b0;
    end
  endtask

  task automatic finishTest();
    if (testOk) begin
      passCount++;
      $display("PASS %s", testName);
    end else begin
      failCount++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host actions
  //////////////////////////////////////////////////////////////////////

  task automatic sendSetup(input logic [63:0] setup);
    for (int k = 0; k < 8; k++) begin
      setupWr = 1'b1;
      setupByte = setup[8*k +: 8];
      @(negedge clk);
    end
    setupWr = 1'b0;
    setupByte = 8'h00;
  endtask

  // Waits for the reply flag, drains EP0 and acknowledges
  task automatic ep0Reply(input testEntry_t entry);
    int n;
    int count;
    while (!(ep0TxReady || ep0Stall)) @(negedge clk);
    checkValue("stall flag", entry.outcome == OUT_STALL, ep0Stall);
    checkValue("txReady flag", entry.outcome != OUT_STALL, ep0TxReady);
    count = (entry.outcome == OUT_DATA) ? int'(entry.count) : 0;
    n = 0;
    while (ep0Valid) begin
      if (n < count) begin
        checkValue($sformatf("byte %0d", n), descCopy[int'(entry.offset) + n], ep0Data);
      end
      ep0RdEn = 1'b1;
      @(negedge clk);
      ep0RdEn = 1'b0;
      repeat ($urandom % 4) @(negedge clk);
      n++;
    end
    checkValue("byte count", count, n);
    ep0Ack = 1'b1;
    @(negedge clk);
    ep0Ack = 1'b0;
    @(negedge clk);
    checkValue("flags after ack", 0, {ep0TxReady, ep0Stall});
  endtask

  // Reads whole reports from EP1 as they arrive
  task automatic readReports(input int reports);
    for (int r = 0; r < reports; r++) begin
      for (int b = 0; b < 3; b++) begin
        while (!ep1Valid) @(negedge clk);
        checkValue($sformatf("report %0d byte %0d", r, b), expectedReport(r, b), ep1Data);
        ep1RdEn = 1'b1;
        @(negedge clk);
        ep1RdEn = 1'b0;
        repeat ($urandom % 4) @(negedge clk);
      end
    end
  endtask

  task automatic runEntry(input int i);
    testEntry_t entry;
    entry = tbl[i];
    testName = testNames[i];
    testOk = 1'b1;
    if (entry.busRst) begin
      busReset = 1'b1;
      @(negedge clk);
      busReset = 1'b0;
      // Long enough for a report to show up if the mouse kept going
      repeat (30) @(negedge clk);
      checkValue("address after bus reset", 0, devAddr);
      checkValue("EP1 valid after bus reset", 0, ep1Valid);
    end
    sendSetup(entry.setup);
    if (entry.reports > 0) begin
      // Both masters compete for the bus here
      fork
        ep0Reply(entry);
        readReports(int'(entry.reports));
      join
    end else begin
      ep0Reply(entry);
    end
    repeat (10) @(negedge clk);
    checkValue("device address", entry.devAddr, devAddr);
    if (entry.devAddr == 8'h00) begin
      checkValue("EP1 valid without address", 0, ep1Valid);
    end
    finishTest();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    busReset = 1'b0;
    setupWr = 1'b0;
    setupByte = 8'h00;
    ep0RdEn = 1'b0;
    ep0Ack = 1'b0;
    ep1RdEn = 1'b0;
    passCount = 0;
    failCount = 0;
    errorCount = 0;

    // Device descriptor, then configuration, interface, HID and endpoint
    descCopy = '{
      8'h12, 8'h01, 8'h10, 8'h01, 8'h00, 8'h00, 8'h00, 8'h40,
      8'h34, 8'h12, 8'h78, 8'h56, 8'h00, 8'h01, 8'h00, 8'h00,
      8'h00, 8'h01,
      8'h09, 8'h02, 8'h22, 8'h00, 8'h01, 8'h01, 8'h00, 8'hA0, 8'h32,
      8'h09, 8'h04, 8'h00, 8'h00, 8'h01, 8'h03, 8'h01, 8'h02, 8'h00,
      8'h09, 8'h21, 8'h10, 8'h01, 8'h00, 8'h01, 8'h22, 8'h32, 8'h00,
      8'h07, 8'h05, 8'h81, 8'h03, 8'h03, 8'h00, 8'h0A
    };

    testNames[0] = "devDesc64";
    tbl[0] = '{mkSetup(8'h80, 8'h06, 16'h0100, 16'h0, 16'd64),
               OUT_DATA, 6'd18, 6'd0, 3'd0, 1'b0, 8'h00};
    testNames[1] = "cfgDesc255";
    tbl[1] = '{mkSetup(8'h80, 8'h06, 16'h0200, 16'h0, 16'd255),
               OUT_DATA, 6'd34, 6'd18, 3'd0, 1'b0, 8'h00};
    // The host asks for less than the descriptor holds
    testNames[2] = "cfgDesc9";
    tbl[2] = '{mkSetup(8'h80, 8'h06, 16'h0200, 16'h0, 16'd9),
               OUT_DATA, 6'd9, 6'd18, 3'd0, 1'b0, 8'h00};
    testNames[3] = "setAddr5";
    tbl[3] = '{mkSetup(8'h00, 8'h05, 16'h0005, 16'h0, 16'd0),
               OUT_ZERO, 6'd0, 6'd0, 3'd0, 1'b0, 8'h05};
    testNames[4] = "devDescWithReports";
    tbl[4] = '{mkSetup(8'h80, 8'h06, 16'h0100, 16'h0, 16'd64),
               OUT_DATA, 6'd18, 6'd0, 3'd4, 1'b0, 8'h05};
    testNames[5] = "unsupportedStall";
    tbl[5] = '{mkSetup(8'h80, 8'h0A, 16'h0000, 16'h0, 16'd1),
               OUT_STALL, 6'd0, 6'd0, 3'd0, 1'b0, 8'h05};
    // After the bus reset the pattern starts over from the right
    testNames[6] = "setAddrAfterBusReset";
    tbl[6] = '{mkSetup(8'h00, 8'h05, 16'h0009, 16'h0, 16'd0),
               OUT_ZERO, 6'd0, 6'd0, 3'd1, 1'b1, 8'h09};

    @(negedge clk);
    while (reset) @(negedge clk);

    testName = "afterReset";
    testOk = 1'b1;
    checkValue("EP0 valid", 0, ep0Valid);
    checkValue("EP1 valid", 0, ep1Valid);
    checkValue("txReady", 0, ep0TxReady);
    checkValue("stall", 0, ep0Stall);
    checkValue("device address", 0, devAddr);
    repeat (40) @(negedge clk);
    checkValue("EP1 valid at address 0", 0, ep1Valid);
    finishTest();

    for (int i = 0; i < NUM_TESTS; i++) begin
      runEntry(i);
    end

    $display("Tests: %0d passed, %0d failed, %0d mismatches", passCount, failCount,
             errorCount);
    if (failCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Ends a run that stalls somewhere in the table
  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk);
    $display("Watchdog expired, the device stopped answering");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* test/clkGen.sv */
`timescale 1ns/1ps

module clkGen (
  output logic clk_o,
  output logic reset_o
);

  // 100 ns period, low for the first half
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset covers five rising edges and drops on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

/* hw/usbDevice.sv */
`timescale 1ns/1ps

module usbDevice (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                busReset_i,
  input  logic                setupWr_i,
  input  usbDevicePkg::byte_t setupByte_i,
  input  logic                ep0RdEn_i,
  input  logic                ep0Ack_i,
  input  logic                ep1RdEn_i,
  output usbDevicePkg::byte_t ep0Data_o,
  output logic                ep0Valid_o,
  output logic                ep0TxReady_o,
  output logic                ep0Stall_o,
  output usbDevicePkg::byte_t ep1Data_o,
  output logic                ep1Valid_o,
  output usbDevicePkg::byte_t devAddr_o
);

  // Master 0 is the control endpoint, master 1 the mouse
  logic                   req0;
  logic                   gnt0;
  usbDevicePkg::busReq_t  bus0;
  logic                   req1;
  logic                   gnt1;
  usbDevicePkg::busReq_t  bus1;
  // Shared register bus after the arbiter
  usbDevicePkg::busReq_t  bus;
  logic                   ack;
  usbDevicePkg::byte_t    rdata;
  // Private descriptor ROM port of EP0
  usbDevicePkg::romAddr_t romAddr;
  usbDevicePkg::byte_t    romData;

  usbRom u_usbRom (
    .clk_i  (clk_i),
    .addr_i (romAddr),
    .data_o (romData)
  );

  ep0Ctrl u_ep0Ctrl (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .busReset_i (busReset_i),
    .req_o      (req0),
    .gnt_i      (gnt0),
    .bus_o      (bus0),
    .ack_i      (ack),
    .rdata_i    (rdata),
    .romAddr_o  (romAddr),
    .romData_i  (romData)
  );

  ep1Mouse u_ep1Mouse (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .busReset_i (busReset_i),
    .req_o      (req1),
    .gnt_i      (gnt1),
    .bus_o      (bus1),
    .ack_i      (ack),
    .rdata_i    (rdata)
  );

  busArbiter u_busArbiter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req0_i  (req0),
    .req1_i  (req1),
    .gnt0_o  (gnt0),
    .gnt1_o  (gnt1),
    .bus0_i  (bus0),
    .bus1_i  (bus1),
    .bus_o   (bus)
  );

  endpointRegs u_endpointRegs (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .busReset_i   (busReset_i),
    .bus_i        (bus),
    .ack_o        (ack),
    .rdata_o      (rdata),
    .setupWr_i    (setupWr_i),
    .setupByte_i  (setupByte_i),
    .ep0RdEn_i    (ep0RdEn_i),
    .ep0Ack_i     (ep0Ack_i),
    .ep1RdEn_i    (ep1RdEn_i),
    .ep0Data_o    (ep0Data_o),
    .ep0Valid_o   (ep0Valid_o),
    .ep0TxReady_o (ep0TxReady_o),
    .ep0Stall_o   (ep0Stall_o),
    .ep1Data_o    (ep1Data_o),
    .ep1Valid_o   (ep1Valid_o),
    .devAddr_o    (devAddr_o)
  );

endmodule

/* hw/endpointRegs.sv */
`timescale 1ns/1ps

module endpointRegs (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  busReset_i,
  input  usbDevicePkg::busReq_t bus_i,
  output logic                  ack_o,
  output usbDevicePkg::byte_t   rdata_o,
  input  logic                  setupWr_i,
  input  usbDevicePkg::byte_t   setupByte_i,
  input  logic                  ep0RdEn_i,
  input  logic                  ep0Ack_i,
  input  logic                  ep1RdEn_i,
  output usbDevicePkg::byte_t   ep0Data_o,
  output logic                  ep0Valid_o,
  output logic                  ep0TxReady_o,
  output logic                  ep0Stall_o,
  output usbDevicePkg::byte_t   ep1Data_o,
  output logic                  ep1Valid_o,
  output usbDevicePkg::byte_t   devAddr_o
);

  // One extra pointer bit tells a full FIFO from an empty one
  typedef logic [usbDevicePkg::FIFO_ADDR_WIDTH:0] fifoPtr_t;

  logic                access;
  logic                wrAccess;
  logic [2:0]          setupCnt;
  usbDevicePkg::byte_t setupBuf [8];
  logic                setupReady;
  logic [1:0]          push;
  logic [1:0]          pop;
  logic [1:0]          fifoValid;
  logic [1:0]          fifoFull;
  usbDevicePkg::byte_t fifoHead [2];

  // An access counts only in the first strobe cycle
  assign access = bus_i.stb && !ack_o;
  assign wrAccess = access && bus_i.we;
  assign push[0] = wrAccess && bus_i.addr == usbDevicePkg::REG_EP0_TXDATA;
  assign push[1] = wrAccess && bus_i.addr == usbDevicePkg::REG_EP1_TXDATA;
  assign pop = {ep1RdEn_i, ep0RdEn_i} & fifoValid;

  //////////////////////////////////////////////////////////////////////
  // Bus slave side
  //////////////////////////////////////////////////////////////////////

  // Ack comes one cycle after stb is first seen
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // Read data is captured with the access and valid during ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (bus_i.addr[7:3] == usbDevicePkg::REG_SETUP0[7:3]) begin
        rdata_o <= setupBuf[bus_i.addr[2:0]];
      end else begin
        case (bus_i.addr)
          usbDevicePkg::REG_EP0_STATUS: rdata_o <= {7'd0, setupReady};
          usbDevicePkg::REG_EP1_STATUS: rdata_o <= {7'd0, !fifoValid[1]};
          usbDevicePkg::REG_DEVADDR: rdata_o <= devAddr_o;
          default: rdata_o <= 8'h00;
        endcase
      end
    end
  end

  // Host writes the setup packet byte by byte
  always_ff @(posedge clk_i) begin
    if (setupWr_i) begin
      setupBuf[setupCnt] <= setupByte_i;
    end
  end

  // Flags the host sees, plus the device address
  always_ff @(posedge clk_i) begin
    if (reset_i || busReset_i) begin
      setupCnt     <= 3'd0;
      setupReady   <= 1'b0;
      ep0TxReady_o <= 1'b0;
      ep0Stall_o   <= 1'b0;
      devAddr_o    <= 8'h00;
    end else begin
      if (setupWr_i) begin
        setupCnt <= setupCnt + 3'd1;
      end
      if (wrAccess && bus_i.addr == usbDevicePkg::REG_EP0_STATUS && bus_i.wdata[0]) begin
        setupReady <= 1'b0;
      end
      // A completing packet wins over a clear in the same cycle
      if (setupWr_i && setupCnt == 3'd7) begin
        setupReady <= 1'b1;
      end
      if (ep0Ack_i) begin
        ep0TxReady_o <= 1'b0;
        ep0Stall_o <= 1'b0;
      end
      if (wrAccess && bus_i.addr == usbDevicePkg::REG_EP0_CTRL) begin
        if (bus_i.wdata[0]) ep0TxReady_o <= 1'b1;
        if (bus_i.wdata[1]) ep0Stall_o <= 1'b1;
      end
      if (wrAccess && bus_i.addr == usbDevicePkg::REG_DEVADDR) begin
        devAddr_o <= bus_i.wdata;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Transmit FIFOs, entry 0 for EP0 and entry 1 for EP1
  //////////////////////////////////////////////////////////////////////

  for (genvar e = 0; e < 2; e++) begin : gFifo
    usbDevicePkg::byte_t mem [usbDevicePkg::FIFO_DEPTH];
    fifoPtr_t            wrPtr;
    fifoPtr_t            rdPtr;

    assign fifoValid[e] = wrPtr != rdPtr;
    assign fifoFull[e] = (wrPtr - rdPtr) == fifoPtr_t'(usbDevicePkg::FIFO_DEPTH);
    // The head is shown before the host pops it
    assign fifoHead[e] = mem[rdPtr[usbDevicePkg::FIFO_ADDR_WIDTH-1:0]];

    always_ff @(posedge clk_i) begin
      if (push[e] && !fifoFull[e]) begin
        mem[wrPtr[usbDevicePkg::FIFO_ADDR_WIDTH-1:0]] <= bus_i.wdata;
      end
    end

    always_ff @(posedge clk_i) begin
      if (reset_i || busReset_i) begin
        wrPtr <= '0;
        rdPtr <= '0;
      end else begin
        if (push[e] && !fifoFull[e]) wrPtr <= wrPtr + 1'b1;
        if (pop[e]) rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  assign ep0Data_o = fifoHead[0];
  assign ep0Valid_o = fifoValid[0];
  assign ep1Data_o = fifoHead[1];
  assign ep1Valid_o = fifoValid[1];

endmodule

/* hw/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req0_i,
  input  logic                  req1_i,
  output logic                  gnt0_o,
  output logic                  gnt1_o,
  input  usbDevicePkg::busReq_t bus0_i,
  input  usbDevicePkg::busReq_t bus1_i,
  output usbDevicePkg::busReq_t bus_o
);

  logic owner;
  logic ownerValid;
  logic lastServed;
  logic ownerReq;

  // The owner keeps the bus for as long as it holds req
  assign ownerReq = owner ? req1_i : req0_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ownerValid <= 1'b0;
      owner      <= 1'b0;
      lastServed <= 1'b1;
    end else if (!ownerValid || !ownerReq) begin
      ownerValid <= req0_i || req1_i;
      // On a tie the master not served last wins
      if (req0_i && req1_i) begin
        owner <= !lastServed;
        lastServed <= !lastServed;
      end else if (req0_i) begin
        owner <= 1'b0;
        lastServed <= 1'b0;
      end else if (req1_i) begin
        owner <= 1'b1;
        lastServed <= 1'b1;
      end
    end
  end

  assign gnt0_o = ownerValid && !owner;
  assign gnt1_o = ownerValid && owner;

  // Without an owner the slave sees an idle bus with stb low
  assign bus_o = !ownerValid ? '0 : (owner ? bus1_i : bus0_i);

endmodule

/* hw/ep1Mouse.sv */
`timescale 1ns/1ps

module ep1Mouse (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  busReset_i,
  output logic                  req_o,
  input  logic                  gnt_i,
  output usbDevicePkg::busReq_t bus_o,
  input  logic                  ack_i,
  input  usbDevicePkg::byte_t   rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    RD_ADDR,
    RD_STAT,
    WR_REPORT
  } state_t;

  state_t              state;
  logic                stbQ;
  logic                done;
  logic [1:0]          byteIdx;
  logic [1:0]          step;
  usbDevicePkg::byte_t dx;
  usbDevicePkg::byte_t dy;

  assign req_o = state != IDLE;
  assign done = stbQ && ack_i;

  // The movement pattern runs right, down, left and up by four counts each
  always_comb begin
    dx = 8'h00;
    dy = 8'h00;
    case (step)
      2'd0: dx = 8'h04;
      2'd1: dy = 8'h04;
      2'd2: dx = 8'hFC;
      default: dy = 8'hFC;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || busReset_i) begin
      state   <= IDLE;
      stbQ    <= 1'b0;
      byteIdx <= 2'd0;
      step    <= 2'd0;
    end else begin
      if (state != IDLE && !stbQ) begin
        stbQ <= gnt_i;
      end else if (done) begin
        stbQ <= 1'b0;
      end
      case (state)
        IDLE: state <= RD_ADDR;
        // Reports wait until the host has assigned an address
        RD_ADDR: if (done) state <= (rdata_i != 8'h00) ? RD_STAT : IDLE;
        RD_STAT: begin
          // Only an empty FIFO takes a report, so none is lost
          if (done) begin
            byteIdx <= 2'd0;
            state <= rdata_i[0] ? WR_REPORT : IDLE;
          end
        end
        WR_REPORT: begin
          if (done) begin
            byteIdx <= byteIdx + 2'd1;
            if (byteIdx == 2'd2) begin
              step <= step + 2'd1;
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    bus_o = '0;
    bus_o.stb = stbQ;
    case (state)
      RD_ADDR: bus_o.addr = usbDevicePkg::REG_DEVADDR;
      RD_STAT: bus_o.addr = usbDevicePkg::REG_EP1_STATUS;
      WR_REPORT: begin
        bus_o.addr = usbDevicePkg::REG_EP1_TXDATA;
        bus_o.we = 1'b1;
        // Byte 0 is the button state, always released
        bus_o.wdata = (byteIdx == 2'd1) ? dx : (byteIdx == 2'd2) ? dy : 8'h00;
      end
      default: ;
    endcase
  end

endmodule

/* hw/ep0Ctrl.sv */
`timescale 1ns/1ps

module ep0Ctrl (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   busReset_i,
  output logic                   req_o,
  input  logic                   gnt_i,
  output usbDevicePkg::busReq_t  bus_o,
  input  logic                   ack_i,
  input  usbDevicePkg::byte_t    rdata_i,
  output usbDevicePkg::romAddr_t romAddr_o,
  input  usbDevicePkg::byte_t    romData_i
);

  typedef enum logic [2:0] {
    IDLE,
    POLL,
    READ_SETUP,
    DECODE,
    COPY,
    WRITE_ADDR,
    WRITE_CTRL,
    CLEAR
  } state_t;

  state_t                 state;
  logic                   stbQ;
  logic                   access;
  logic                   done;
  logic [2:0]             setupIdx;
  usbDevicePkg::byte_t    setupBuf [8];
  logic [15:0]            wLength;
  logic                   descHit;
  usbDevicePkg::romAddr_t descOff;
  usbDevicePkg::romAddr_t descMax;
  usbDevicePkg::romAddr_t descLen;
  usbDevicePkg::romAddr_t descOffset;
  usbDevicePkg::romAddr_t txLen;
  usbDevicePkg::romAddr_t txIdx;
  logic                   stallReq;

  // The bus is requested for the whole sequence, from poll to clear
  assign req_o = state != IDLE;
  // Every state except IDLE and DECODE performs one bus access
  assign access = (state != IDLE) && (state != DECODE);
  assign done = stbQ && ack_i;
  assign romAddr_o = descOffset + txIdx;

  // Setup bytes 6 and 7 carry wLength, little endian
  assign wLength = {setupBuf[7], setupBuf[6]};

  //////////////////////////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    descHit = setupBuf[1] == usbDevicePkg::REQ_GET_DESCRIPTOR;
    descOff = usbDevicePkg::DEV_DESC_OFFSET;
    descMax = usbDevicePkg::DEV_DESC_LEN;
    // The descriptor type is the high byte of wValue
    if (setupBuf[3] == usbDevicePkg::DESC_CONFIG) begin
      descOff = usbDevicePkg::CFG_DESC_OFFSET;
      descMax = usbDevicePkg::CFG_DESC_LEN;
    end else if (setupBuf[3] != usbDevicePkg::DESC_DEVICE) begin
      descHit = 1'b0;
    end
    // The host may ask for less than the whole descriptor
    descLen = (wLength < {10'd0, descMax}) ? wLength[5:0] : descMax;
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i || busReset_i) begin
      state    <= IDLE;
      stbQ     <= 1'b0;
      setupIdx <= 3'd0;
      txIdx    <= '0;
    end else begin
      // Strobe rises once granted and drops in the cycle after ack
      if (access && !stbQ) begin
        stbQ <= gnt_i;
      end else if (done) begin
        stbQ <= 1'b0;
      end
      case (state)
        IDLE: state <= POLL;
        POLL: begin
          if (done) begin
            state <= rdata_i[0] ? READ_SETUP : IDLE;
          end
        end
        READ_SETUP: begin
          // The index wraps to zero after the eighth byte
          if (done) begin
            setupBuf[setupIdx] <= rdata_i;
            setupIdx <= setupIdx + 3'd1;
            if (setupIdx == 3'd7) begin
              state <= DECODE;
            end
          end
        end
        DECODE: begin
          txIdx <= '0;
          stallReq <= 1'b0;
          if (descHit) begin
            descOffset <= descOff;
            txLen <= descLen;
            state <= (descLen == '0) ? WRITE_CTRL : COPY;
          end else if (setupBuf[1] == usbDevicePkg::REQ_SET_ADDRESS) begin
            state <= WRITE_ADDR;
          end else begin
            stallReq <= 1'b1;
            state <= WRITE_CTRL;
          end
        end
        COPY: begin
          if (done) begin
            txIdx <= txIdx + 6'd1;
            if (txIdx == txLen - 6'd1) begin
              state <= WRITE_CTRL;
            end
          end
        end
        WRITE_ADDR: if (done) state <= WRITE_CTRL;
        WRITE_CTRL: if (done) state <= CLEAR;
        CLEAR: if (done) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Address and data follow the state, so they hold still until ack
  always_comb begin
    bus_o = '0;
    bus_o.stb = stbQ;
    case (state)
      POLL: bus_o.addr = usbDevicePkg::REG_EP0_STATUS;
      READ_SETUP: bus_o.addr = usbDevicePkg::REG_SETUP0 + {5'd0, setupIdx};
      COPY: begin
        // ROM data settles in the idle cycle before each strobe
        bus_o.addr = usbDevicePkg::REG_EP0_TXDATA;
        bus_o.we = 1'b1;
        bus_o.wdata = romData_i;
      end
      WRITE_ADDR: begin
        bus_o.addr = usbDevicePkg::REG_DEVADDR;
        bus_o.we = 1'b1;
        bus_o.wdata = setupBuf[2];
      end
      WRITE_CTRL: begin
        bus_o.addr = usbDevicePkg::REG_EP0_CTRL;
        bus_o.we = 1'b1;
        bus_o.wdata = {6'd0, stallReq, !stallReq};
      end
      CLEAR: begin
        bus_o.addr = usbDevicePkg::REG_EP0_STATUS;
        bus_o.we = 1'b1;
        bus_o.wdata = 8'h01;
      end
      default: ;
    endcase
  end

endmodule

/* hw/usbRom.sv */
`timescale 1ns/1ps

module usbRom (
  input  logic                   clk_i,
  input  usbDevicePkg::romAddr_t addr_i,
  output usbDevicePkg::byte_t    data_o
);

  // Device descriptor followed directly by the whole configuration
  usbDevicePkg::byte_t romTable [usbDevicePkg::DEV_DESC_LEN + usbDevicePkg::CFG_DESC_LEN];

  // Device descriptor, USB 1.1, 64-byte EP0, one configuration
  // Class codes sit in the interface, so the device level is zero
  assign romTable = '{
    8'h12, 8'h01, 8'h10, 8'h01, 8'h00, 8'h00, 8'h00, 8'h40,
    8'h34, 8'h12, 8'h78, 8'h56, 8'h00, 8'h01, 8'h00, 8'h00,
    8'h00, 8'h01,
    // Configuration, 34 bytes in total, bus powered at 100 mA
    8'h09, 8'h02, 8'h22, 8'h00, 8'h01, 8'h01, 8'h00, 8'hA0,
    8'h32,
    // Interface 0 with one endpoint, HID boot class, mouse protocol
    8'h09, 8'h04, 8'h00, 8'h00, 8'h01, 8'h03, 8'h01, 8'h02,
    8'h00,
    // HID descriptor pointing at a 50-byte report descriptor
    8'h09, 8'h21, 8'h10, 8'h01, 8'h00, 8'h01, 8'h22, 8'h32,
    8'h00,
    // Endpoint 1 IN, interrupt, 3-byte reports every 10 frames
    8'h07, 8'h05, 8'h81, 8'h03, 8'h03, 8'h00, 8'h0A
  };

  // Registered read, addresses past the table return zero
  always_ff @(posedge clk_i) begin
    if (addr_i < usbDevicePkg::DEV_DESC_LEN + usbDevicePkg::CFG_DESC_LEN) begin
      data_o <= romTable[addr_i];
    end else begin
      data_o <= 8'h00;
    end
  end

endmodule

/* hw/usbDevicePkg.sv */
package usbDevicePkg;

  // Widths that carry a meaning on the register bus and the ROM port
  typedef logic [7:0] byte_t;
  typedef logic [7:0] regAddr_t;
  typedef logic [5:0] romAddr_t;

  // One master access on the register bus, held stable from stb until ack
  typedef struct packed {
    regAddr_t addr;
    byte_t    wdata;
    logic     we;
    logic     stb;
  } busReq_t;

  //////////////////////////////////////////////////////////////////////
  // Register map of the endpoint block
  //////////////////////////////////////////////////////////////////////

  // Eight read-only setup bytes start here
  localparam regAddr_t REG_SETUP0     = 8'h00;
  // Bit0 is setupReady, writing a 1 clears it
  localparam regAddr_t REG_EP0_STATUS = 8'h10;
  localparam regAddr_t REG_EP0_TXDATA = 8'h11;
  // Bit0 sets txReady, bit1 sets stall
  localparam regAddr_t REG_EP0_CTRL   = 8'h12;
  // Bit0 is high while the EP1 FIFO is empty
  localparam regAddr_t REG_EP1_STATUS = 8'h20;
  localparam regAddr_t REG_EP1_TXDATA = 8'h21;
  localparam regAddr_t REG_DEVADDR    = 8'h30;

  // Standard request codes and descriptor types that EP0 understands
  localparam byte_t REQ_GET_DESCRIPTOR = 8'd6;
  localparam byte_t REQ_SET_ADDRESS    = 8'd5;
  localparam byte_t DESC_DEVICE        = 8'd1;
  localparam byte_t DESC_CONFIG        = 8'd2;

  // Descriptor placement inside the ROM
  localparam romAddr_t DEV_DESC_OFFSET = 6'd0;
  localparam romAddr_t DEV_DESC_LEN    = 6'd18;
  localparam romAddr_t CFG_DESC_OFFSET = 6'd18;
  localparam romAddr_t CFG_DESC_LEN    = 6'd34;

  // Both transmit FIFOs share one depth
  localparam int FIFO_DEPTH      = 64;
  localparam int FIFO_ADDR_WIDTH = 6;

endpackage
